// ==== include/muldiv_defines.svh ====
////////////////////
// Shared widths of the multiply/divide unit
// Operand width and transaction id width
////////////////////

`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// Integer register width of the core
// The divider alignment logic expects a power of two here
`define MULDIV_XLEN 32

// Width of the transaction id carried with every operation
// Sets how many operations the issuing side may keep apart
`define MULDIV_ID_BITS 4

`endif

// ==== src/muldiv_op_pkg.sv ====
////////////////////
// Operation types of the multiply/divide unit
////////////////////

package muldiv_op_pkg;

  // Operations accepted on the input port
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } muldiv_op_e;

  // Multiplier variant
  // SEL_MUL returns the low word, the others the high word
  typedef enum logic [1:0] {
    SEL_MUL    = 2'd0,
    SEL_MULH   = 2'd1,
    SEL_MULHSU = 2'd2,
    SEL_MULHU  = 2'd3
  } mul_sel_e;

  // Divides and remainders go to the serial divider
  function automatic logic is_div_op(muldiv_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  // Multiplier variant of a multiply opcode
  function automatic mul_sel_e mul_sel_of(muldiv_op_e op);
    case (op)
      OP_MULH:   return SEL_MULH;
      OP_MULHSU: return SEL_MULHSU;
      OP_MULHU:  return SEL_MULHU;
      default:   return SEL_MUL;
    endcase
  endfunction

endpackage

// ==== src/muldiv_trans_pkg.sv ====
////////////////////
// Transaction types of the multiply/divide unit
////////////////////

`include "muldiv_defines.svh"

package muldiv_trans_pkg;

  // Id that travels with an operation and comes back with its result
  typedef logic [`MULDIV_ID_BITS-1:0] trans_id_t;

  // Divider opcode
  // 0 udiv, 1 div, 2 urem, 3 rem
  typedef logic [1:0] div_opcode_t;

  // Bit positions inside div_opcode_t
  localparam int unsigned DIV_SIGNED_BIT = 0;
  localparam int unsigned DIV_REM_BIT    = 1;

endpackage

// ==== src/lzc.sv ====
////////////////////
// Leading-zero counter
// Pairwise reduction tree with an all-zero flag
////////////////////

`timescale 1ns/1ps

`include "muldiv_defines.svh"

module lzc #(
  // Must be a power of two
  parameter int unsigned WIDTH = `MULDIV_XLEN
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int unsigned LOG_W = $clog2(WIDTH);

  // Tree nodes, reduced in place level by level
  // Node 0 ends up holding the count over the whole word
  logic [LOG_W-1:0] node_cnt [WIDTH];
  logic             node_vld [WIDTH];

  always_comb begin
    // Leaves, index 0 is the MSB
    for (int i = 0; i < WIDTH; i++) begin
      node_vld[i] = in_i[WIDTH-1-i];
      node_cnt[i] = '0;
    end
    // Each level merges a left and a right half
    // Left half wins if it holds a one, else skip its full size
    for (int l = 0; l < LOG_W; l++) begin
      for (int n = 0; n < (WIDTH >> (l + 1)); n++) begin
        node_cnt[n] = node_vld[2*n] ? node_cnt[2*n]
                                    : node_cnt[2*n+1] + LOG_W'(1 << l);
        node_vld[n] = node_vld[2*n] | node_vld[2*n+1];
      end
    end
  end

  assign cnt_o   = node_cnt[0];
  // No one anywhere in the word
  assign empty_o = ~node_vld[0];

endmodule

// ==== src/serdiv.sv ====
////////////////////
// Serial radix-2 divider
// One quotient bit per cycle, early exit and signed fixup
////////////////////

`timescale 1ns/1ps

`include "muldiv_defines.svh"

module serdiv (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  muldiv_trans_pkg::trans_id_t   id_i,
  input  logic [`MULDIV_XLEN-1:0]       op_a_i,
  input  logic [`MULDIV_XLEN-1:0]       op_b_i,
  input  muldiv_trans_pkg::div_opcode_t opcode_i,
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic                          flush_i,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output muldiv_trans_pkg::trans_id_t   id_o,
  output logic [`MULDIV_XLEN-1:0]       res_o
);

  import muldiv_trans_pkg::*;

  localparam int unsigned W     = `MULDIV_XLEN;
  localparam int unsigned LOG_W = $clog2(W);
  // Shift used when operand A is all zeros
  localparam logic [LOG_W:0] FULL_SHIFT = (LOG_W + 1)'(W);

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } state_e;

  state_e state_q, state_d;

  // Partial remainder, shifted divisor and quotient
  logic [W-1:0] op_a_q;
  logic [W-1:0] op_b_q;
  logic [W-1:0] res_q;
  trans_id_t    id_q;

  logic [LOG_W-1:0] cnt_q, cnt_d;
  logic             cnt_zero;

  // Flags captured at load
  logic rem_sel_q, comp_inv_q, res_inv_q;
  logic b_zero_q, b_neg_one_q, div_res_zero_q;

  logic is_signed, a_sign, b_sign;
  logic b_zero, b_neg_one, early_done;

  logic [W-1:0]     lzc_a_in, lzc_b_in;
  logic [LOG_W-1:0] lzc_a_cnt, lzc_b_cnt;
  logic             lzc_a_empty, lzc_b_empty;
  logic [LOG_W:0]   shift_a;
  logic [LOG_W+1:0] div_shift;
  logic [W-1:0]     op_b_shifted;

  logic [W-1:0] add_mux, add_tmp, add_out, b_mux, out_mux;
  logic         pm_sel, ab_comp;
  logic         load_en, a_reg_en, b_reg_en, res_reg_en;

  ////////////////////
  // Operand alignment
  ////////////////////

  assign is_signed = opcode_i[DIV_SIGNED_BIT];
  assign a_sign    = op_a_i[W-1];
  assign b_sign    = op_b_i[W-1];

  // Magnitude-like view of each operand for the counters
  assign lzc_a_in = (is_signed & a_sign) ? {~op_a_i[W-2:0], 1'b1} : op_a_i;
  assign lzc_b_in = (is_signed & b_sign) ? ~op_b_i : op_b_i;

  lzc #(
    .WIDTH (W)
  ) i_lzc_a (
    .in_i    (lzc_a_in),
    .cnt_o   (lzc_a_cnt),
    .empty_o (lzc_a_empty)
  );

  lzc #(
    .WIDTH (W)
  ) i_lzc_b (
    .in_i    (lzc_b_in),
    .cnt_o   (lzc_b_cnt),
    .empty_o (lzc_b_empty)
  );

  // Empty B view means 0, or -1 when the sign bit is set
  assign b_zero    = lzc_b_empty & ~b_sign;
  assign b_neg_one = lzc_b_empty & b_sign;

  assign shift_a      = lzc_a_empty ? FULL_SHIFT : {1'b0, lzc_a_cnt};
  assign div_shift    = {2'b00, lzc_b_cnt} - {1'b0, shift_a};
  assign op_b_shifted = op_b_i << div_shift;

  ////////////////////
  // Datapath
  ////////////////////

  // Add on load when signs agree, subtract otherwise
  assign pm_sel  = load_en & ~(is_signed & (a_sign ^ b_sign));
  assign add_mux = load_en ? op_a_i : op_b_q;
  assign add_tmp = load_en ? '0 : op_a_q;
  assign add_out = pm_sel ? add_tmp + add_mux : add_tmp - add_mux;

  // Divisor walks right by one, filled with its sign for negative B
  assign b_mux = load_en ? op_b_shifted : {comp_inv_q, op_b_q[W-1:1]};

  // Compare partial remainder against divisor
  assign ab_comp = ((op_a_q == op_b_q) | ((op_a_q > op_b_q) ^ comp_inv_q))
                 & ((|op_a_q) | b_zero_q);

  // Corner results: x/0 is all ones, x%0 is a, x/-1 is -a, x%-1 is 0
  always_comb begin
    if (rem_sel_q) begin
      out_mux = b_neg_one_q ? '0 : op_a_q;
    end else if (b_zero_q) begin
      out_mux = '1;
    end else begin
      out_mux = b_neg_one_q ? op_a_q : res_q;
    end
  end

  // Sign fixup on the way out
  assign res_o = res_inv_q ? -out_mux : out_mux;
  assign id_o  = id_q;

  ////////////////////
  // FSM and counter
  ////////////////////

  // Result known without iterating
  assign early_done = div_res_zero_q | b_zero_q | b_neg_one_q;

  assign cnt_zero = (cnt_q == '0);
  assign cnt_d    = load_en  ? div_shift[LOG_W-1:0] :
                    cnt_zero ? cnt_q : cnt_q - 1'b1;

  always_comb begin
    state_d     = state_q;
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    load_en     = 1'b0;
    a_reg_en    = 1'b0;
    b_reg_en    = 1'b0;
    res_reg_en  = 1'b0;

    unique case (state_q)
      IDLE: begin
        // Ready drops in the accepting cycle
        in_ready_o = ~in_valid_i;
        if (in_valid_i) begin
          load_en  = 1'b1;
          a_reg_en = 1'b1;
          b_reg_en = 1'b1;
          state_d  = DIVIDE;
        end
      end
      DIVIDE: begin
        if (early_done) begin
          out_valid_o = 1'b1;
          state_d     = out_ready_i ? IDLE : FINISH;
        end else begin
          // Subtract only when the divisor fits
          a_reg_en   = ab_comp;
          b_reg_en   = 1'b1;
          res_reg_en = 1'b1;
          if (cnt_zero) begin
            state_d = FINISH;
          end
        end
      end
      FINISH: begin
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush drops the operation wherever it is
    if (flush_i) begin
      in_ready_o  = 1'b0;
      out_valid_o = 1'b0;
      load_en     = 1'b0;
      a_reg_en    = 1'b0;
      b_reg_en    = 1'b0;
      res_reg_en  = 1'b0;
      state_d     = IDLE;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= IDLE;
      cnt_q          <= '0;
      rem_sel_q      <= 1'b0;
      comp_inv_q     <= 1'b0;
      res_inv_q      <= 1'b0;
      b_zero_q       <= 1'b0;
      b_neg_one_q    <= 1'b0;
      div_res_zero_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (load_en) begin
        rem_sel_q      <= opcode_i[DIV_REM_BIT];
        comp_inv_q     <= is_signed & b_sign;
        // Negate for mixed signs, except a quotient by zero
        res_inv_q      <= (~b_zero | opcode_i[DIV_REM_BIT]) & is_signed
                        & (a_sign ^ b_sign ^ b_neg_one);
        b_zero_q       <= b_zero;
        b_neg_one_q    <= b_neg_one;
        // Negative shift means |b| > |a|, quotient is zero
        div_res_zero_q <= div_shift[LOG_W+1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_reg_en) begin
      op_a_q <= add_out;
    end
    if (b_reg_en) begin
      op_b_q <= b_mux;
    end
    // Quotient bits enter from the right
    if (load_en) begin
      res_q <= '0;
      id_q  <= id_i;
    end else if (res_reg_en) begin
      res_q <= {res_q[W-2:0], ab_comp};
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Result and valid hold until taken or flushed
  a_out_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      (out_valid_o && $stable(res_o) && $stable(id_o)) || flush_i
  ) else $error("serdiv result dropped or changed under back-pressure");

  a_ready_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    in_ready_o |-> state_q == IDLE
  ) else $error("serdiv ready outside IDLE");

endmodule

// ==== src/multiplier.sv ====
////////////////////
// Two-stage pipelined multiplier
// Signed and unsigned variants, low or high word
////////////////////

`timescale 1ns/1ps

`include "muldiv_defines.svh"

module multiplier (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  muldiv_op_pkg::mul_sel_e     sel_i,
  input  logic [`MULDIV_XLEN-1:0]     a_i,
  input  logic [`MULDIV_XLEN-1:0]     b_i,
  input  muldiv_trans_pkg::trans_id_t id_i,
  input  logic                        flush_i,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output muldiv_trans_pkg::trans_id_t id_o,
  output logic [`MULDIV_XLEN-1:0]     result_o
);

  import muldiv_op_pkg::*;
  import muldiv_trans_pkg::*;

  localparam int unsigned W = `MULDIV_XLEN;

  // Whole pipe moves together
  logic advance;
  logic a_signed, b_signed;

  // Stage 1: extended operands, then the full product
  logic                op_valid_q;
  logic signed [W:0]   op_a_q, op_b_q;
  logic                op_high_q;
  trans_id_t           op_id_q;
  logic signed [2*W+1:0] product;
  logic                s1_valid_q;
  logic [2*W-1:0]      s1_prod_q;
  logic                s1_high_q;
  trans_id_t           s1_id_q;

  // Stage 2: selected half
  logic                s2_valid_q;
  logic [W-1:0]        s2_res_q;
  trans_id_t           s2_id_q;

  // Stall only while the output holds an unaccepted result
  assign advance    = ~s2_valid_q | out_ready_i;
  assign in_ready_o = advance;

  // Sign of each operand per variant
  assign a_signed = (sel_i == SEL_MULH) | (sel_i == SEL_MULHSU);
  assign b_signed = (sel_i == SEL_MULH);

  // 33x33 signed product covers all variants
  assign product = op_a_q * op_b_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_valid_q <= 1'b0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (flush_i) begin
      op_valid_q <= 1'b0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      op_valid_q <= in_valid_i;
      s1_valid_q <= op_valid_q;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      op_a_q    <= {a_signed & a_i[W-1], a_i};
      op_b_q    <= {b_signed & b_i[W-1], b_i};
      op_high_q <= (sel_i != SEL_MUL);
      op_id_q   <= id_i;
      s1_prod_q <= product[2*W-1:0];
      s1_high_q <= op_high_q;
      s1_id_q   <= op_id_q;
      s2_res_q  <= s1_high_q ? s1_prod_q[2*W-1:W] : s1_prod_q[W-1:0];
      s2_id_q   <= s1_id_q;
    end
  end

  assign out_valid_o = s2_valid_q;
  assign id_o        = s2_id_q;
  assign result_o    = s2_res_q;

  // Output payload holds while stalled
  a_s2_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> $stable(result_o) && $stable(id_o)
  ) else $error("multiplier output changed under back-pressure");

endmodule

// ==== src/muldiv_unit.sv ====
////////////////////
// Multiply/divide unit top
// Steers operations and shares one result port
////////////////////

`timescale 1ns/1ps

`include "muldiv_defines.svh"

module muldiv_unit (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        flush_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  muldiv_op_pkg::muldiv_op_e   in_op_i,
  input  logic [`MULDIV_XLEN-1:0]     in_a_i,
  input  logic [`MULDIV_XLEN-1:0]     in_b_i,
  input  muldiv_trans_pkg::trans_id_t in_id_i,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output muldiv_trans_pkg::trans_id_t out_id_o,
  output logic [`MULDIV_XLEN-1:0]     out_result_o
);

  import muldiv_op_pkg::*;
  import muldiv_trans_pkg::*;

  logic        is_div;
  div_opcode_t div_opcode;
  mul_sel_e    mul_sel;

  logic                   mul_in_valid, mul_in_ready;
  logic                   mul_out_valid;
  trans_id_t              mul_id;
  logic [`MULDIV_XLEN-1:0] mul_result;

  logic                   div_in_valid, div_in_ready;
  logic                   div_out_valid, div_out_ready;
  trans_id_t              div_id;
  logic [`MULDIV_XLEN-1:0] div_result;

  ////////////////////
  // Opcode decode
  ////////////////////

  assign is_div  = is_div_op(in_op_i);
  assign mul_sel = mul_sel_of(in_op_i);

  always_comb begin
    div_opcode                 = '0;
    div_opcode[DIV_SIGNED_BIT] = (in_op_i == OP_DIV) | (in_op_i == OP_REM);
    div_opcode[DIV_REM_BIT]    = (in_op_i == OP_REM) | (in_op_i == OP_REMU);
  end

  // Valid only reaches the selected unit
  assign mul_in_valid = in_valid_i & ~is_div;
  assign div_in_valid = in_valid_i & is_div;
  assign in_ready_o   = is_div ? div_in_ready : mul_in_ready;

  multiplier i_multiplier (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (mul_in_valid),
    .in_ready_o  (mul_in_ready),
    .sel_i       (mul_sel),
    .a_i         (in_a_i),
    .b_i         (in_b_i),
    .id_i        (in_id_i),
    .flush_i     (flush_i),
    .out_valid_o (mul_out_valid),
    .out_ready_i (out_ready_i),
    .id_o        (mul_id),
    .result_o    (mul_result)
  );

  serdiv i_serdiv (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .id_i        (in_id_i),
    .op_a_i      (in_a_i),
    .op_b_i      (in_b_i),
    .opcode_i    (div_opcode),
    .in_valid_i  (div_in_valid),
    .in_ready_o  (div_in_ready),
    .flush_i     (flush_i),
    .out_valid_o (div_out_valid),
    .out_ready_i (div_out_ready),
    .id_o        (div_id),
    .res_o       (div_result)
  );

  ////////////////////
  // Result arbitration
  ////////////////////

  // Multiplier first, divider waits holding its result
  assign div_out_ready = out_ready_i & ~mul_out_valid;
  assign out_valid_o   = mul_out_valid | div_out_valid;
  assign out_id_o      = mul_out_valid ? mul_id : div_id;
  assign out_result_o  = mul_out_valid ? mul_result : div_result;

  // A divide result kept off the port by the multiplier is not lost
  a_div_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mul_out_valid && div_out_valid && !flush_i |=>
      (div_out_valid && $stable(div_id) && $stable(div_result)) || flush_i
  ) else $error("divider result lost while the multiplier held the result port");

endmodule

// ==== bench/clk_gen.sv ====
////////////////////
// Testbench clock and reset
////////////////////

`timescale 1ns/1ps

module clk_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held low, released just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// ==== bench/tb_muldiv.sv ====
////////////////////
// Testbench of the multiply/divide unit
// Reads vectors, drives the DUT, checks results by id
////////////////////

`timescale 1ns/1ps

`include "muldiv_defines.svh"

module tb_muldiv;

  import muldiv_op_pkg::*;
  import muldiv_trans_pkg::*;

  localparam int unsigned XLEN          = `MULDIV_XLEN;
  localparam int unsigned NUM_IDS       = 1 << `MULDIV_ID_BITS;
  localparam int unsigned MAX_VECS      = 64;
  localparam int unsigned WORDS_PER_VEC = 5;
  // Cycles from accept to flush for a flushed divide
  localparam int unsigned FLUSH_DELAY   = 4;

  logic            clk, rst_n;
  logic            flush;
  logic            in_valid, in_ready;
  muldiv_op_e      in_op;
  logic [XLEN-1:0] in_a, in_b;
  trans_id_t       in_id;
  logic            out_valid, out_ready;
  trans_id_t       out_id;
  logic [XLEN-1:0] out_result;

  // Word 0 is the vector count, then five words per vector
  logic [31:0] vec_mem [0:MAX_VECS*WORDS_PER_VEC];

  // Scoreboard indexed by id
  logic            busy     [NUM_IDS];
  logic            exp_div  [NUM_IDS];
  logic [XLEN-1:0] exp_res  [NUM_IDS];
  int              issue_no [NUM_IDS];

  int     num_vecs, issued, outstanding, returned;
  int     value_errors, other_errors, overtakes;
  int     cycles, timeout_limit;
  integer seed;

  // Output held in the previous sample
  logic            hold_q;
  trans_id_t       hold_id;
  logic [XLEN-1:0] hold_res;
  logic            hold_div;
  logic            flush_seen;

  clk_gen #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (10)
  ) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  muldiv_unit i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .flush_i      (flush),
    .in_valid_i   (in_valid),
    .in_ready_o   (in_ready),
    .in_op_i      (in_op),
    .in_a_i       (in_a),
    .in_b_i       (in_b),
    .in_id_i      (in_id),
    .out_valid_o  (out_valid),
    .out_ready_i  (out_ready),
    .out_id_o     (out_id),
    .out_result_o (out_result)
  );

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s at %0t", msg, $time);
    other_errors++;
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  // Sampled mid-cycle, all inputs settled long before
  always @(negedge clk) begin
    trans_id_t id;
    if (rst_n) begin
      id = out_id;
      // Stalled result must still be there, unless a multiply took the port
      if (hold_q && !flush_seen) begin
        if (!out_valid) begin
          note_failure("out_valid_o dropped before the result was taken");
        end else if (id != hold_id && hold_div && busy[id] && !exp_div[id]) begin
          // Multiplier priority over a waiting divide
        end else begin
          compare_value("out_id_o", XLEN'(id), XLEN'(hold_id));
          compare_value("out_result_o", out_result, hold_res);
        end
      end
      // Transfer at the coming edge
      if (out_valid && out_ready) begin
        if (!busy[id]) begin
          note_failure($sformatf("result for id %0d that is not outstanding", id));
        end else begin
          compare_value("out_result_o", out_result, exp_res[id]);
          // Count results passing an older divide
          for (int i = 0; i < NUM_IDS; i++) begin
            if (busy[i] && exp_div[i] && issue_no[i] < issue_no[id]) begin
              overtakes++;
              break;
            end
          end
          busy[id] = 1'b0;
          outstanding--;
          returned++;
        end
      end
      hold_q     = out_valid && !out_ready;
      hold_id    = id;
      hold_res   = out_result;
      hold_div   = exp_div[id];
      flush_seen = flush;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    integer      rnd;
    int          base;
    int          flush_wait;
    trans_id_t   id, flush_id;
    logic        want_flush;
    seed         = 63;
    flush        = 1'b0;
    in_valid     = 1'b0;
    in_op        = OP_MUL;
    in_a         = '0;
    in_b         = '0;
    in_id        = '0;
    out_ready    = 1'b0;
    issued       = 0;
    outstanding  = 0;
    returned     = 0;
    value_errors = 0;
    other_errors = 0;
    overtakes    = 0;
    cycles       = 0;
    flush_wait   = 0;
    flush_id     = '0;
    hold_q       = 1'b0;
    flush_seen   = 1'b0;
    for (int i = 0; i < NUM_IDS; i++) begin
      busy[i]     = 1'b0;
      exp_div[i]  = 1'b0;
      exp_res[i]  = '0;
      issue_no[i] = 0;
    end
    $readmemh("bench/muldiv_input.txt", vec_mem);
    num_vecs = vec_mem[0];
    if (num_vecs == 0 || num_vecs > MAX_VECS) begin
      note_failure("vector file is missing or holds a bad vector count");
      num_vecs = 0;
    end
    timeout_limit = num_vecs * (XLEN + 8);
    @(posedge rst_n);
    // Idle unit after reset, ready and nothing to return
    #1;
    compare_value("in_ready_o", XLEN'(in_ready), XLEN'(1'b1));
    compare_value("out_valid_o", XLEN'(out_valid), XLEN'(1'b0));
    while (issued < num_vecs || outstanding > 0) begin
      @(posedge clk);
      #1;
      rnd       = $random(seed);
      out_ready = (rnd[1:0] != 2'b00);
      in_valid  = 1'b0;
      flush     = 1'b0;
      if (flush_wait > 0) begin
        // Divide still running, drop it
        flush_wait--;
        if (flush_wait == 0) begin
          flush          = 1'b1;
          busy[flush_id] = 1'b0;
          outstanding--;
        end
      end else if (issued < num_vecs) begin
        base       = 1 + issued * WORDS_PER_VEC;
        id         = trans_id_t'(issued % NUM_IDS);
        want_flush = vec_mem[base+4][0];
        // A flushed divide runs alone
        if (!busy[id] && !(want_flush && outstanding > 0)) begin
          in_op = muldiv_op_e'(vec_mem[base][2:0]);
          in_a  = vec_mem[base+1];
          in_b  = vec_mem[base+2];
          in_id = id;
          // Ready seen with valid low means the next edge accepts
          #1;
          if (in_ready) begin
            in_valid     = 1'b1;
            busy[id]     = 1'b1;
            exp_res[id]  = vec_mem[base+3];
            exp_div[id]  = in_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
            issue_no[id] = issued;
            issued++;
            outstanding++;
            if (want_flush) begin
              flush_id   = id;
              flush_wait = FLUSH_DELAY;
            end
          end
        end
      end
    end
    // Quiet tail, a flushed result must not show up
    repeat (XLEN + 4) @(posedge clk);
    // Long divides in the vectors leave room for a multiply to come back first
    if (overtakes == 0) begin
      note_failure("no multiply returned ahead of an older divide");
    end
    $display("results %0d of %0d, value errors %0d, other errors %0d",
             returned, num_vecs, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  ////////////////////
  // Timeout
  ////////////////////

  initial begin
    @(posedge rst_n);
    while (cycles < timeout_limit) begin
      @(posedge clk);
      cycles++;
    end
    note_failure($sformatf("timeout after %0d cycles", cycles));
    for (int i = 0; i < NUM_IDS; i++) begin
      if (busy[i]) begin
        note_failure($sformatf("no result returned for id %0d", i));
      end
    end
    $display("results %0d of %0d, value errors %0d, other errors %0d",
             returned, num_vecs, value_errors, other_errors);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== bench/muldiv_input.txt ====
// First word: number of vectors
// Then per line: opcode a b expected flush (opcode 0 MUL .. 7 REMU, flush 1 drops it)
00000021
// Multiplies, low and high words
0 00000007 00000006 0000002a 0
0 ffffffff ffffffff 00000001 0
1 ffffffff ffffffff 00000000 0
3 ffffffff ffffffff fffffffe 0
2 ffffffff ffffffff ffffffff 0
3 80000000 00000002 00000001 0
2 80000000 00000002 ffffffff 0
1 80000000 80000000 40000000 0
1 7fffffff 7fffffff 3fffffff 0
0 12345678 00000010 23456780 0
0 80000000 ffffffff 80000000 0
// Long divide followed by multiplies that overtake it
4 00000064 00000007 0000000e 0
5 ffffffff 00000003 55555555 0
0 00000003 fffffffd fffffff7 0
3 00010000 00010000 00000001 0
// Signed and unsigned divides and remainders
4 ffffff9c 00000007 fffffff2 0
6 ffffff9c 00000007 fffffffe 0
6 00000064 fffffff9 00000002 0
4 00000064 fffffff9 fffffff2 0
7 ffffffff 00000010 0000000f 0
5 00000005 00000009 00000000 0
7 00000005 00000009 00000005 0
4 fffffffb 00000009 00000000 0
6 fffffffb 00000009 fffffffb 0
// Division by zero
4 00000007 00000000 ffffffff 0
5 00000007 00000000 ffffffff 0
6 00000007 00000000 00000007 0
7 00000007 00000000 00000007 0
// Most negative by minus one
4 80000000 ffffffff 80000000 0
6 80000000 ffffffff 00000000 0
// Flushed divide, then work goes on
5 ffffffff 00000003 55555555 1
4 ffffff9c 00000007 fffffff2 0
0 00000007 00000006 0000002a 0

// ==== muldiv.f ====
+incdir+include
src/muldiv_op_pkg.sv
src/muldiv_trans_pkg.sv
src/lzc.sv
src/serdiv.sv
src/multiplier.sv
src/muldiv_unit.sv
bench/clk_gen.sv
bench/tb_muldiv.sv

// ==== Makefile ====
BUILD := build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f muldiv.f \
		--top-module tb_muldiv --Mdir $(BUILD) -o sim_muldiv
	./$(BUILD)/sim_muldiv | tee $(BUILD)/sim.log
	grep -q "all tests passed" $(BUILD)/sim.log

clean:
	rm -rf $(BUILD)
